//--- src/ita_lite_pkg.sv
// ========================================
// constants, lane types and vector types
// shared by the tiled matmul engine
// ========================================
package ita_lite_pkg;

  localparam int N         = 4;   // output lanes
  localparam int M         = 4;   // beats per inner tile
  localparam int FifoDepth = 2;   // power of two, also the initial credit count
  localparam int CntW      = 8;   // tile counters and job dimensions
  localparam int AccW      = 24;
  localparam int RqMultW   = 8;   // unsigned requant multiplier
  localparam int RqShiftW  = 5;

  // fill and credit counts span 0 .. FifoDepth
  localparam int CreditW = $clog2(FifoDepth + 1);
  localparam int PtrW    = $clog2(FifoDepth);

  localparam logic [CreditW-1:0] CreditInit = CreditW'(FifoDepth);

  // one signed int8 operand
  typedef logic signed [7:0] operand_t;

  // per lane int8 weights
  typedef logic [N-1:0][7:0] weight_vec_t;

  // per lane int16 biases
  typedef logic [N-1:0][15:0] bias_vec_t;

  // per lane partial sums
  typedef logic [N-1:0][AccW-1:0] acc_vec_t;

  // per lane int8 results
  typedef logic [N-1:0][7:0] oup_vec_t;

  // set bit marks a real lane, clear bit a padded one
  typedef logic [N-1:0] lane_mask_t;

endpackage

//--- src/ita_lite_beat_if.sv
// ========================================
// accepted operand beat with its tile
// position, controller to MAC
// ========================================
`timescale 1ns/1ps

interface ita_lite_beat_if;

  logic                      fire;        // beat accepted this cycle
  ita_lite_pkg::operand_t    x;
  ita_lite_pkg::weight_vec_t w;
  logic                      first_beat;  // beat 0 of inner tile 0
  logic                      last_beat;   // final beat of final inner tile
  ita_lite_pkg::lane_mask_t  mask;

  modport controller (
    output fire, x, w, first_beat, last_beat, mask
  );

  modport dotp (
    input fire, x, w, first_beat, last_beat, mask
  );

endinterface

//--- src/ita_lite_operand_join.sv
// ========================================
// operand join: cross-coupled readies,
// beat fire and per tile bias register
// ========================================
`timescale 1ns/1ps

module ita_lite_operand_join (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      inp_valid_i,
  input  ita_lite_pkg::operand_t    inp_i,
  input  logic                      weight_valid_i,
  input  ita_lite_pkg::weight_vec_t weight_i,
  input  logic                      bias_valid_i,
  input  ita_lite_pkg::bias_vec_t   bias_i,
  input  logic                      accept_en_i,
  output logic                      inp_ready_o,
  output logic                      weight_ready_o,
  output logic                      bias_ready_o,
  output logic                      beat_fire_o,
  output ita_lite_pkg::operand_t    x_o,
  output ita_lite_pkg::weight_vec_t w_o,
  output ita_lite_pkg::bias_vec_t   bias_o
);

  ita_lite_pkg::bias_vec_t bias_q;

  // each ready waits on the other two streams
  assign inp_ready_o    = accept_en_i && weight_valid_i && bias_valid_i;
  assign weight_ready_o = accept_en_i && inp_valid_i && bias_valid_i;
  assign bias_ready_o   = accept_en_i && inp_valid_i && weight_valid_i;

  assign beat_fire_o = accept_en_i && inp_valid_i && weight_valid_i && bias_valid_i;

  assign x_o    = inp_i;
  assign w_o    = weight_i;
  assign bias_o = bias_q;

  // last loaded bias is read by the output side one cycle after tile completion
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bias_q <= '0;
    end else if (beat_fire_o) begin
      bias_q <= bias_i;
    end
  end

endmodule

//--- src/ita_lite_controller.sv
// ========================================
// tile walker, lane padding mask and
// output credit counter
// ========================================
`timescale 1ns/1ps

module ita_lite_controller (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  logic [ita_lite_pkg::CntW-1:0]     tile_s_i,      // row tiles
  input  logic [ita_lite_pkg::CntW-1:0]     tile_p_i,      // column tiles
  input  logic [ita_lite_pkg::CntW-1:0]     tile_e_i,      // inner tiles
  input  logic [ita_lite_pkg::CntW-1:0]     proj_space_i,
  input  logic                              beat_fire_i,
  input  ita_lite_pkg::operand_t            x_i,
  input  ita_lite_pkg::weight_vec_t         w_i,
  input  logic                              credit_i,
  output logic                              accept_en_o,
  output logic                              busy_o,
  ita_lite_beat_if.controller               beat
);

  logic [ita_lite_pkg::CntW-1:0]    count_q;       // beat within inner tile
  logic [ita_lite_pkg::CntW-1:0]    inner_tile_q;
  logic [ita_lite_pkg::CntW-1:0]    tile_x_q;
  logic [ita_lite_pkg::CntW-1:0]    tile_y_q;
  logic [ita_lite_pkg::CreditW-1:0] credit_q;
  logic                             busy_q;        // low means idle
  logic                             last_count;
  logic                             last_inner;
  logic                             last_x;
  logic                             last_y;
  logic                             spend;
  ita_lite_pkg::lane_mask_t         mask;

  assign last_count = (count_q == ita_lite_pkg::M - 1);
  assign last_inner = (inner_tile_q == tile_e_i - 1'b1);
  assign last_x     = (tile_x_q == tile_p_i - 1'b1);
  assign last_y     = (tile_y_q == tile_s_i - 1'b1);

  assign accept_en_o = busy_q && (credit_q != '0);
  assign busy_o      = busy_q;

  // a tile leaves the MAC when its last beat is accepted
  assign spend = beat_fire_i && last_count && last_inner;

  // lane i is real while tile_x*N + i stays below proj_space
  always_comb begin
    for (int i = 0; i < ita_lite_pkg::N; i++) begin
      mask[i] = (int'(tile_x_q) * ita_lite_pkg::N + i) < int'(proj_space_i);
    end
  end

  assign beat.fire       = beat_fire_i;
  assign beat.x          = x_i;
  assign beat.w          = w_i;
  assign beat.first_beat = (count_q == '0) && (inner_tile_q == '0);
  assign beat.last_beat  = last_count && last_inner;
  assign beat.mask       = mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      count_q      <= '0;
      inner_tile_q <= '0;
      tile_x_q     <= '0;
      tile_y_q     <= '0;
    end else if (!busy_q) begin
      if (start_i) begin
        busy_q       <= 1'b1;
        count_q      <= '0;
        inner_tile_q <= '0;
        tile_x_q     <= '0;
        tile_y_q     <= '0;
      end
    end else if (beat_fire_i) begin
      if (!last_count) begin
        count_q <= count_q + 1'b1;
      end else begin
        count_q <= '0;
        if (!last_inner) begin
          inner_tile_q <= inner_tile_q + 1'b1;
        end else begin
          inner_tile_q <= '0;
          if (!last_x) begin
            tile_x_q <= tile_x_q + 1'b1;
          end else begin
            tile_x_q <= '0;
            if (!last_y) begin
              tile_y_q <= tile_y_q + 1'b1;
            end else begin
              tile_y_q <= '0;
              busy_q   <= 1'b0;  // final beat of the job
            end
          end
        end
      end
    end
  end

  // one credit per free output FIFO entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= ita_lite_pkg::CreditInit;
    end else if (spend && !credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (!spend && credit_i) begin
      credit_q <= credit_q + 1'b1;
    end
  end

endmodule

//--- src/ita_lite_dotp.sv
// ========================================
// N-lane multiply-accumulate with tile
// completion strobe
// ========================================
`timescale 1ns/1ps

module ita_lite_dotp (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  ita_lite_beat_if.dotp            beat,
  output logic                     done_o,
  output ita_lite_pkg::acc_vec_t   acc_o,
  output ita_lite_pkg::lane_mask_t mask_o
);

  ita_lite_pkg::acc_vec_t   acc_d;
  ita_lite_pkg::acc_vec_t   acc_q;
  ita_lite_pkg::acc_vec_t   res_q;
  ita_lite_pkg::lane_mask_t mask_q;
  logic                     done_q;

  always_comb begin
    logic signed [ita_lite_pkg::AccW-1:0] prod;
    for (int i = 0; i < ita_lite_pkg::N; i++) begin
      prod = $signed(beat.x) * $signed(beat.w[i]);  // sign extended before the multiply
      if (beat.first_beat) begin
        acc_d[i] = prod;  // drop the previous tile
      end else begin
        acc_d[i] = acc_q[i] + prod;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat.fire) begin
      acc_q <= acc_d;
    end
    if (beat.fire && beat.last_beat) begin
      res_q  <= acc_d;      // held until the next completion
      mask_q <= beat.mask;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= beat.fire && beat.last_beat;
    end
  end

  assign done_o = done_q;
  assign acc_o  = res_q;
  assign mask_o = mask_q;

endmodule

//--- src/ita_lite_requant_fifo.sv
// ========================================
// bias add, requant, int8 saturation,
// lane masking and output FIFO
// ========================================
`timescale 1ns/1ps

module ita_lite_requant_fifo (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                done_i,
  input  ita_lite_pkg::acc_vec_t              acc_i,
  input  ita_lite_pkg::lane_mask_t            mask_i,
  input  ita_lite_pkg::bias_vec_t             bias_i,
  input  logic [ita_lite_pkg::RqMultW-1:0]    rq_mult_i,
  input  logic [ita_lite_pkg::RqShiftW-1:0]   rq_shift_i,
  input  ita_lite_pkg::operand_t              rq_add_i,
  input  logic                                oup_ready_i,
  output logic                                oup_valid_o,
  output ita_lite_pkg::oup_vec_t              oup_data_o,
  output logic                                credit_o
);

  ita_lite_pkg::oup_vec_t           rq_vec;
  ita_lite_pkg::oup_vec_t           mem_q [ita_lite_pkg::FifoDepth];
  logic [ita_lite_pkg::PtrW-1:0]    wr_ptr_q;
  logic [ita_lite_pkg::PtrW-1:0]    rd_ptr_q;
  logic [ita_lite_pkg::CreditW-1:0] fill_q;
  logic                             push;
  logic                             pop;

  always_comb begin
    logic signed [ita_lite_pkg::AccW:0]                      sum;
    logic signed [ita_lite_pkg::AccW+ita_lite_pkg::RqMultW+1:0] prod;
    logic signed [ita_lite_pkg::AccW+ita_lite_pkg::RqMultW+2:0] rq;
    for (int i = 0; i < ita_lite_pkg::N; i++) begin
      sum  = $signed(acc_i[i]) + $signed(bias_i[i]);
      prod = sum * $signed({1'b0, rq_mult_i});
      rq   = (prod >>> rq_shift_i) + rq_add_i;
      if (!mask_i[i]) begin
        rq_vec[i] = '0;     // padded lane
      end else if (rq > 127) begin
        rq_vec[i] = 8'h7f;
      end else if (rq < -128) begin
        rq_vec[i] = 8'h80;
      end else begin
        rq_vec[i] = rq[7:0];
      end
    end
  end

  // credits keep a push from ever meeting a full FIFO
  assign push        = done_i;
  assign pop         = oup_valid_o && oup_ready_i;
  assign oup_valid_o = (fill_q != '0);
  assign oup_data_o  = mem_q[rd_ptr_q];
  assign credit_o    = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rq_vec;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (!push && pop) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

endmodule

//--- src/ita_lite_top.sv
// ========================================
// linear layer matmul engine top level
// ========================================
`timescale 1ns/1ps

module ita_lite_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  logic [ita_lite_pkg::CntW-1:0]     tile_s_i,
  input  logic [ita_lite_pkg::CntW-1:0]     tile_p_i,
  input  logic [ita_lite_pkg::CntW-1:0]     tile_e_i,
  input  logic [ita_lite_pkg::CntW-1:0]     proj_space_i,
  input  logic [ita_lite_pkg::RqMultW-1:0]  rq_mult_i,
  input  logic [ita_lite_pkg::RqShiftW-1:0] rq_shift_i,
  input  ita_lite_pkg::operand_t            rq_add_i,
  input  logic                              inp_valid_i,
  input  ita_lite_pkg::operand_t            inp_i,
  output logic                              inp_ready_o,
  input  logic                              weight_valid_i,
  input  ita_lite_pkg::weight_vec_t         weight_i,
  output logic                              weight_ready_o,
  input  logic                              bias_valid_i,
  input  ita_lite_pkg::bias_vec_t           bias_i,
  output logic                              bias_ready_o,
  output logic                              oup_valid_o,
  input  logic                              oup_ready_i,
  output ita_lite_pkg::oup_vec_t            oup_data_o,
  output logic                              busy_o
);

  logic                      accept_en;
  logic                      beat_fire;
  logic                      credit;
  logic                      done;
  ita_lite_pkg::operand_t    beat_x;
  ita_lite_pkg::weight_vec_t beat_w;
  ita_lite_pkg::bias_vec_t   tile_bias;
  ita_lite_pkg::acc_vec_t    dotp_acc;
  ita_lite_pkg::lane_mask_t  dotp_mask;

  ita_lite_beat_if beat_if ();

  ita_lite_operand_join operand_join_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .inp_valid_i    (inp_valid_i),
    .inp_i          (inp_i),
    .weight_valid_i (weight_valid_i),
    .weight_i       (weight_i),
    .bias_valid_i   (bias_valid_i),
    .bias_i         (bias_i),
    .accept_en_i    (accept_en),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .beat_fire_o    (beat_fire),
    .x_o            (beat_x),
    .w_o            (beat_w),
    .bias_o         (tile_bias)
  );

  ita_lite_controller controller_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .tile_s_i     (tile_s_i),
    .tile_p_i     (tile_p_i),
    .tile_e_i     (tile_e_i),
    .proj_space_i (proj_space_i),
    .beat_fire_i  (beat_fire),
    .x_i          (beat_x),
    .w_i          (beat_w),
    .credit_i     (credit),
    .accept_en_o  (accept_en),
    .busy_o       (busy_o),
    .beat         (beat_if.controller)
  );

  ita_lite_dotp dotp_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .beat   (beat_if.dotp),
    .done_o (done),
    .acc_o  (dotp_acc),
    .mask_o (dotp_mask)
  );

  ita_lite_requant_fifo requant_fifo_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .done_i      (done),
    .acc_i       (dotp_acc),
    .mask_i      (dotp_mask),
    .bias_i      (tile_bias),
    .rq_mult_i   (rq_mult_i),
    .rq_shift_i  (rq_shift_i),
    .rq_add_i    (rq_add_i),
    .oup_ready_i (oup_ready_i),
    .oup_valid_o (oup_valid_o),
    .oup_data_o  (oup_data_o),
    .credit_o    (credit)
  );

endmodule

//--- testbench/ita_lite_top_assert.sv
// ========================================
// output stall, idle ready and reset
// assertions for the matmul top level
// ========================================
`timescale 1ns/1ps

module ita_lite_top_assert (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   busy_i,
  input logic                   inp_ready_i,
  input logic                   weight_ready_i,
  input logic                   bias_ready_i,
  input logic                   oup_valid_i,
  input logic                   oup_ready_i,
  input ita_lite_pkg::oup_vec_t oup_data_i
);

  int fail_count;  // read by the testbench at the end

  initial fail_count = 0;

  stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    oup_valid_i && !oup_ready_i |=> $stable(oup_data_i))
    else begin
      fail_count++;
      $error("oup_data_o changed while the output was stalled");
    end

  idle_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_i |-> !(inp_ready_i || weight_ready_i || bias_ready_i))
    else begin
      fail_count++;
      $error("an operand ready is high while the engine is idle");
    end

  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> !busy_i && !oup_valid_i)
    else begin
      fail_count++;
      $error("busy_o or oup_valid_o is high during reset");
    end

endmodule

bind ita_lite_top ita_lite_top_assert top_assert_inst (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .busy_i         (busy_o),
  .inp_ready_i    (inp_ready_o),
  .weight_ready_i (weight_ready_o),
  .bias_ready_i   (bias_ready_o),
  .oup_valid_i    (oup_valid_o),
  .oup_ready_i    (oup_ready_i),
  .oup_data_i     (oup_data_o)
);

//--- testbench/tb_ita_lite_top.sv
// ========================================
// trace-driven testbench with random
// valids, back-pressure and a watchdog
// ========================================
`timescale 1ns/1ps

module tb_ita_lite_top;

  localparam int TraceWords    = 1024;
  localparam int CyclesPerItem = 20;

  logic                              clk_i = 1'b0;
  logic                              rst_ni;
  logic                              start_i;
  logic [ita_lite_pkg::CntW-1:0]     tile_s_i;
  logic [ita_lite_pkg::CntW-1:0]     tile_p_i;
  logic [ita_lite_pkg::CntW-1:0]     tile_e_i;
  logic [ita_lite_pkg::CntW-1:0]     proj_space_i;
  logic [ita_lite_pkg::RqMultW-1:0]  rq_mult_i;
  logic [ita_lite_pkg::RqShiftW-1:0] rq_shift_i;
  ita_lite_pkg::operand_t            rq_add_i;
  logic                              inp_valid_i;
  ita_lite_pkg::operand_t            inp_i;
  logic                              inp_ready_o;
  logic                              weight_valid_i;
  ita_lite_pkg::weight_vec_t         weight_i;
  logic                              weight_ready_o;
  logic                              bias_valid_i;
  ita_lite_pkg::bias_vec_t           bias_i;
  logic                              bias_ready_o;
  logic                              oup_valid_o;
  logic                              oup_ready_i;
  ita_lite_pkg::oup_vec_t            oup_data_o;
  logic                              busy_o;

  logic [31:0]                       trace_mem [TraceWords];
  logic [ita_lite_pkg::CntW-1:0]     job_s [$];
  logic [ita_lite_pkg::CntW-1:0]     job_p [$];
  logic [ita_lite_pkg::CntW-1:0]     job_e [$];
  logic [ita_lite_pkg::CntW-1:0]     job_proj [$];
  logic [ita_lite_pkg::RqMultW-1:0]  job_mult [$];
  logic [ita_lite_pkg::RqShiftW-1:0] job_shift [$];
  ita_lite_pkg::operand_t            job_add [$];
  int                                job_beats [$];
  int                                job_results [$];
  ita_lite_pkg::operand_t            beat_x [$];
  ita_lite_pkg::weight_vec_t         beat_w [$];
  ita_lite_pkg::bias_vec_t           beat_b [$];
  ita_lite_pkg::oup_vec_t            exp_q [$];

  logic [15:0] lfsr_q;
  int          beat_idx;
  int          beat_end;
  int          driven_idx;  // beat currently on the operand inputs
  int          recv_cnt;
  int          recv_end;
  int          data_errors;
  int          ctrl_errors;
  int          assert_errors;
  int          limit_cycles;

  ita_lite_top ita_lite_top_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .tile_s_i       (tile_s_i),
    .tile_p_i       (tile_p_i),
    .tile_e_i       (tile_e_i),
    .proj_space_i   (proj_space_i),
    .rq_mult_i      (rq_mult_i),
    .rq_shift_i     (rq_shift_i),
    .rq_add_i       (rq_add_i),
    .inp_valid_i    (inp_valid_i),
    .inp_i          (inp_i),
    .inp_ready_o    (inp_ready_o),
    .weight_valid_i (weight_valid_i),
    .weight_i       (weight_i),
    .weight_ready_o (weight_ready_o),
    .bias_valid_i   (bias_valid_i),
    .bias_i         (bias_i),
    .bias_ready_o   (bias_ready_o),
    .oup_valid_o    (oup_valid_o),
    .oup_ready_i    (oup_ready_i),
    .oup_data_o     (oup_data_o),
    .busy_o         (busy_o)
  );

  always #2 clk_i = ~clk_i;

  // galois form, taps 16 14 13 11
  function automatic logic rand_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 16'hb400;
    end
    return out;
  endfunction

  task automatic load_trace();
    int                        idx;
    int                        cur_job;
    ita_lite_pkg::weight_vec_t w;
    ita_lite_pkg::bias_vec_t   b;
    ita_lite_pkg::oup_vec_t    o;
    idx = 0;
    $readmemh("testbench/ita_lite_trace.txt", trace_mem);
    while (idx < TraceWords - 10 && (trace_mem[idx] === 32'd1 ||
           trace_mem[idx] === 32'd2 || trace_mem[idx] === 32'd3)) begin
      cur_job = job_beats.size() - 1;
      if (trace_mem[idx] == 32'd1) begin
        job_s.push_back(trace_mem[idx+1][ita_lite_pkg::CntW-1:0]);
        job_p.push_back(trace_mem[idx+2][ita_lite_pkg::CntW-1:0]);
        job_e.push_back(trace_mem[idx+3][ita_lite_pkg::CntW-1:0]);
        job_proj.push_back(trace_mem[idx+4][ita_lite_pkg::CntW-1:0]);
        job_mult.push_back(trace_mem[idx+5][ita_lite_pkg::RqMultW-1:0]);
        job_shift.push_back(trace_mem[idx+6][ita_lite_pkg::RqShiftW-1:0]);
        job_add.push_back(trace_mem[idx+7][7:0]);
        job_beats.push_back(0);
        job_results.push_back(0);
        idx = idx + 8;
      end else if (trace_mem[idx] == 32'd2) begin
        for (int i = 0; i < ita_lite_pkg::N; i++) begin
          w[i] = trace_mem[idx+2+i][7:0];
          b[i] = trace_mem[idx+6+i][15:0];
        end
        beat_x.push_back(trace_mem[idx+1][7:0]);
        beat_w.push_back(w);
        beat_b.push_back(b);
        job_beats[cur_job] = job_beats[cur_job] + 1;
        idx = idx + 10;
      end else begin
        for (int i = 0; i < ita_lite_pkg::N; i++) begin
          o[i] = trace_mem[idx+1+i][7:0];
        end
        exp_q.push_back(o);
        job_results[cur_job] = job_results[cur_job] + 1;
        idx = idx + 5;
      end
    end
    if (trace_mem[idx] !== 32'd0) begin
      $display("trace file has an unknown tag or no end marker at word %0d", idx);
      ctrl_errors++;
    end
  endtask

  task automatic check_result();
    if (recv_cnt >= recv_end) begin
      $display("an output vector arrived at %0t when none was expected", $time);
      data_errors++;
    end else begin
      if (oup_data_o !== exp_q[recv_cnt]) begin
        $display("FAIL @%0t: result %0d is %h, expected %h",
                 $time, recv_cnt, oup_data_o, exp_q[recv_cnt]);
        data_errors++;
      end
      recv_cnt++;
    end
  endtask

  // drive on the falling edge, sample handshakes once the outputs have settled
  task automatic step_cycle();
    @(negedge clk_i);
    start_i = 1'b0;
    if (busy_o !== (beat_idx < beat_end)) begin
      $display("FAIL @%0t: busy_o is %b with %0d beats left to send",
               $time, busy_o, beat_end - beat_idx);
      ctrl_errors++;
    end
    if (beat_idx < beat_end) begin
      if (driven_idx != beat_idx) begin
        driven_idx     = beat_idx;
        inp_i          = beat_x[beat_idx];
        weight_i       = beat_w[beat_idx];
        bias_i         = beat_b[beat_idx];
        inp_valid_i    = 1'b0;
        weight_valid_i = 1'b0;
        bias_valid_i   = 1'b0;
      end
      if (!inp_valid_i) begin
        inp_valid_i = rand_bit();  // held once raised
      end
      if (!weight_valid_i) begin
        weight_valid_i = rand_bit();
      end
      if (!bias_valid_i) begin
        bias_valid_i = rand_bit();
      end
    end else begin
      inp_valid_i    = 1'b0;
      weight_valid_i = 1'b0;
      bias_valid_i   = 1'b0;
    end
    oup_ready_i = rand_bit();
    #1;  // settled, well before the rising edge
    if (inp_valid_i && inp_ready_o) begin
      if (!weight_ready_o || !bias_ready_o) begin
        $display("operand readies disagree on the beat accepted at %0t", $time);
        ctrl_errors++;
      end
      beat_idx++;
    end
    if (oup_valid_o && oup_ready_i) begin
      check_result();
    end
    @(posedge clk_i);
  endtask

  task automatic run_job(input int j);
    if (job_beats[j] != int'(job_s[j]) * int'(job_p[j]) * int'(job_e[j]) * ita_lite_pkg::M ||
        job_results[j] != int'(job_s[j]) * int'(job_p[j])) begin
      $display("trace job %0d has beat or result counts that do not fit its tiles", j);
      ctrl_errors++;
    end
    @(negedge clk_i);
    tile_s_i     = job_s[j];
    tile_p_i     = job_p[j];
    tile_e_i     = job_e[j];
    proj_space_i = job_proj[j];
    rq_mult_i    = job_mult[j];
    rq_shift_i   = job_shift[j];
    rq_add_i     = job_add[j];
    start_i      = 1'b1;
    oup_ready_i  = 1'b0;
    beat_end     = beat_end + job_beats[j];
    recv_end     = recv_end + job_results[j];
    @(posedge clk_i);
    while (beat_idx < beat_end || recv_cnt < recv_end) begin
      step_cycle();
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    tile_s_i       = '0;
    tile_p_i       = '0;
    tile_e_i       = '0;
    proj_space_i   = '0;
    rq_mult_i      = '0;
    rq_shift_i     = '0;
    rq_add_i       = '0;
    inp_valid_i    = 1'b0;
    inp_i          = '0;
    weight_valid_i = 1'b0;
    weight_i       = '0;
    bias_valid_i   = 1'b0;
    bias_i         = '0;
    oup_ready_i    = 1'b0;
    lfsr_q         = 16'd15;
    beat_idx       = 0;
    beat_end       = 0;
    driven_idx     = -1;
    recv_cnt       = 0;
    recv_end       = 0;
    data_errors    = 0;
    ctrl_errors    = 0;
    load_trace();
    if (job_s.size() == 0) begin
      $display("no jobs were read from the trace file");
      ctrl_errors++;
    end
    limit_cycles = (beat_x.size() + exp_q.size()) * CyclesPerItem;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    if (busy_o !== 1'b0 || oup_valid_o !== 1'b0 || inp_ready_o !== 1'b0) begin
      $display("busy_o, oup_valid_o or inp_ready_o is not low after reset");
      ctrl_errors++;
    end
    for (int j = 0; j < job_s.size(); j++) begin
      run_job(j);
    end
    repeat (4) step_cycle();  // no stray results
    assert_errors = ita_lite_top_inst.top_assert_inst.fail_count;
    $display("checks done: %0d data errors, %0d control errors, %0d assertion errors",
             data_errors, ctrl_errors, assert_errors);
    if (data_errors + ctrl_errors + assert_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles with %0d of %0d results received",
             limit_cycles, recv_cnt, exp_q.size());
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- ita_lite_top.f
src/ita_lite_pkg.sv
src/ita_lite_beat_if.sv
src/ita_lite_operand_join.sv
src/ita_lite_controller.sv
src/ita_lite_dotp.sv
src/ita_lite_requant_fifo.sv
src/ita_lite_top.sv
testbench/ita_lite_top_assert.sv
testbench/tb_ita_lite_top.sv

//--- testbench/ita_lite_trace.txt
// job 1 tile_s tile_p tile_e proj_space rq_mult rq_shift rq_add | end 0
// beat 2 x w0..w3 b0..b3 | result 3 o0..o3 | hex, lane 0 first
// two column tiles, one inner tile, full lanes
1 01 02 01 08 03 02 01
2 02 01 ff 03 00 000a fffc 0007 0014
2 fd 02 04 ff 05 000a fffc 0007 0014
2 01 fe 03 02 01 000a fffc 0007 0014
2 04 01 00 fe 03 000a fffc 0007 0014
2 05 01 02 00 ff fffa 0003 0000 0001
2 ff 03 01 02 02 fffa 0003 0000 0001
2 02 00 fe 04 01 fffa 0003 0000 0001
2 fe 02 01 fd 00 fffa 0003 0000 0001
3 07 f5 08 0e
3 fb 05 0a fe
// two rows, three inner tiles each
1 02 01 03 04 01 00 00
2 01 01 02 ff 05 0000 0001 0002 0003
2 01 01 02 ff 05 0000 0001 0002 0003
2 01 01 02 ff 05 0000 0001 0002 0003
2 01 01 02 ff 05 0000 0001 0002 0003
2 01 02 02 fe 05 0000 0001 0002 0003
2 01 02 02 fe 05 0000 0001 0002 0003
2 01 02 02 fe 05 0000 0001 0002 0003
2 01 02 02 fe 05 0000 0001 0002 0003
2 01 03 02 fd 05 0000 0001 0002 0003
2 01 03 02 fd 05 0000 0001 0002 0003
2 01 03 02 fd 05 0000 0001 0002 0003
2 01 03 02 fd 05 0000 0001 0002 0003
2 02 01 00 fd 00 ffff 0000 0005 0007
2 02 01 00 fd 00 ffff 0000 0005 0007
2 02 01 00 fd 00 ffff 0000 0005 0007
2 02 01 00 fd 00 ffff 0000 0005 0007
2 02 01 01 fd 00 ffff 0000 0005 0007
2 02 01 01 fd 00 ffff 0000 0005 0007
2 02 01 01 fd 00 ffff 0000 0005 0007
2 02 01 01 fd 00 ffff 0000 0005 0007
2 02 01 02 fd 00 ffff 0000 0005 0007
2 02 01 02 fd 00 ffff 0000 0005 0007
2 02 01 02 fd 00 ffff 0000 0005 0007
2 02 01 02 fd 00 ffff 0000 0005 0007
3 18 19 ea 3f
3 17 18 bd 07
// saturation in tile 0, lanes 2 and 3 padded in tile 1
1 01 02 01 06 04 01 fd
2 64 64 9c 00 00 0000 0000 ffc2 0041
2 64 64 9c 00 00 0000 0000 ffc2 0041
2 64 64 9c 00 00 0000 0000 ffc2 0041
2 64 64 9c 00 00 0000 0000 ffc2 0041
2 03 02 fd 07 09 0001 0004 0032 0032
2 fe 02 fd 07 09 0001 0004 0032 0032
2 01 02 fd 07 09 0001 0004 0032 0032
2 05 02 fd 07 09 0001 0004 0032 0032
3 7f 80 81 7f
3 1b db 00 00
0
